//--- filelist.f
rtl/mc_pkg.sv
rtl/burst_handler.sv
rtl/timing_controller.sv
rtl/dram_model.sv
rtl/mem_ctrl_top.sv
testbench/mem_ctrl_assertions.sv
testbench/mem_ctrl_tb.sv

//--- rtl/burst_handler.sv
`timescale 1ns/1ns

module burst_handler #(
	parameter int no_of_bursts = 4
) (
	input logic clk,
	input logic rst_n,

	// client side
	input logic req_valid,
	input mc_pkg::req_type_t req_type,
	input logic [mc_pkg::addr_width-1:0] req_addr,
	input logic [mc_pkg::data_width-1:0] req_data,
	input logic [mc_pkg::tag_width-1:0] req_tag,
	output logic [$clog2(no_of_bursts+1)-1:0] free_bursts,

	// timing controller side
	input logic svc_start,
	input logic svc_done,
	input logic [$clog2(no_of_bursts)-1:0] svc_id,
	input logic beat_valid,
	input logic [mc_pkg::slot_width-1:0] beat_slot,
	input logic [$clog2(no_of_bursts)-1:0] beat_id,
	output mc_pkg::burst_state_t [no_of_bursts-1:0] burst_state,
	output mc_pkg::req_type_t [no_of_bursts-1:0] burst_type,
	output logic [no_of_bursts-1:0][mc_pkg::row_width+mc_pkg::col_width-1:0] burst_row,

	// dram data path
	input logic mem_rd_valid,
	input logic [mc_pkg::slot_width-1:0] mem_rd_slot,
	input logic [mc_pkg::data_width-1:0] mem_rd_data,
	output logic [mc_pkg::data_width-1:0] mem_wr_data,
	output logic mem_wr_en,

	// responses
	output logic resp_valid,
	output mc_pkg::req_type_t resp_type,
	output logic [mc_pkg::tag_width-1:0] resp_tag,
	output logic [mc_pkg::data_width-1:0] resp_data
);

	localparam int id_width = $clog2(no_of_bursts);
	localparam int fw = $clog2(no_of_bursts+1); // free counter width

	// per buffer storage
	logic [mc_pkg::data_width-1:0] data_q [no_of_bursts][mc_pkg::burst_length];
	logic [mc_pkg::tag_width-1:0] tag_q [no_of_bursts][mc_pkg::burst_length];
	logic [mc_pkg::burst_length-1:0] mask [no_of_bursts]; // occupied slots

	logic [id_width-1:0] fill_id; // buffer taking requests
	logic [id_width-1:0] cap_id; // buffer of the beat before, for read data

	logic [mc_pkg::slot_width-1:0] req_slot;
	logic [mc_pkg::row_width+mc_pkg::col_width-1:0] req_burst;

	logic any_empty;
	logic [id_width-1:0] alloc_id, tgt_id;
	logic join_hit, alloc, close;

	logic ret_any, ret_has, rel_en;
	logic [id_width-1:0] ret_id;
	logic [mc_pkg::slot_width-1:0] ret_slot;
	logic [mc_pkg::burst_length-1:0] ret_mask;

	assign req_slot = req_addr[mc_pkg::slot_width-1:0];
	assign req_burst = req_addr[mc_pkg::addr_width-1:mc_pkg::slot_width]; // row + column

	// first empty buffer
	always_comb begin
		alloc_id = '0;
		any_empty = 1'b0;
		for (int i = no_of_bursts-1; i >= 0; i--) begin // downward so lowest wins
			if (burst_state[i] == mc_pkg::empty) begin
				alloc_id = id_width'(i);
				any_empty = 1'b1;
			end
		end
	end

	// merge rule
	// a filling buffer means the cycle before carried a request
	always_comb begin
		join_hit = req_valid
			&& burst_state[fill_id] == mc_pkg::filling
			&& burst_row[fill_id] == req_burst
			&& burst_type[fill_id] == req_type
			&& !mask[fill_id][req_slot];
		alloc = req_valid && !join_hit && any_empty; // dropped if nothing free
		close = burst_state[fill_id] == mc_pkg::filling && !join_hit;
		tgt_id = join_hit ? fill_id : alloc_id;
	end

	// lowest returning buffer, then its lowest occupied slot
	always_comb begin
		ret_id = '0;
		ret_any = 1'b0;
		for (int i = no_of_bursts-1; i >= 0; i--) begin
			if (burst_state[i] == mc_pkg::returning) begin
				ret_id = id_width'(i);
				ret_any = 1'b1;
			end
		end
		ret_mask = ret_any ? mask[ret_id] : '0; // nothing returning, no slot
		ret_slot = '0;
		ret_has = 1'b0;
		for (int s = mc_pkg::burst_length-1; s >= 0; s--) begin
			if (ret_mask[s]) begin
				ret_slot = mc_pkg::slot_width'(s);
				ret_has = 1'b1;
			end
		end
		rel_en = ret_any && !ret_has; // mask drained, free it
	end

	// write beats read straight out of the buffer
	assign mem_wr_data = data_q[beat_id][beat_slot];
	assign mem_wr_en = beat_valid && burst_type[beat_id] == mc_pkg::write_req
		&& mask[beat_id][beat_slot];

	// buffer states, masks, free count
	always_ff @(posedge clk) begin
		if (rst_n) begin // rst_n high clears
			for (int i = 0; i < no_of_bursts; i++) begin
				burst_state[i] <= mc_pkg::empty;
				mask[i] <= '0;
			end
			fill_id <= '0;
			free_bursts <= fw'(no_of_bursts);
			resp_valid <= 1'b0;
		end else begin
			if (close)
				burst_state[fill_id] <= mc_pkg::full;
			if (join_hit)
				mask[fill_id][req_slot] <= 1'b1;
			if (alloc) begin
				burst_state[alloc_id] <= mc_pkg::filling;
				mask[alloc_id] <= mc_pkg::burst_length'(1) << req_slot; // only the new slot
				fill_id <= alloc_id;
			end
			if (svc_start)
				burst_state[svc_id] <= mc_pkg::in_service;
			if (svc_done)
				burst_state[svc_id] <= mc_pkg::returning;

			resp_valid <= 1'b0;
			if (ret_has) begin
				resp_valid <= 1'b1;
				mask[ret_id][ret_slot] <= 1'b0;
			end
			if (rel_en)
				burst_state[ret_id] <= mc_pkg::empty;

			// alloc and release can land in the same cycle
			free_bursts <= free_bursts - fw'(alloc) + fw'(rel_en);
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (alloc) begin
			burst_type[alloc_id] <= req_type;
			burst_row[alloc_id] <= req_burst;
		end
		if (join_hit || alloc) begin
			tag_q[tgt_id][req_slot] <= req_tag;
			if (req_type == mc_pkg::write_req)
				data_q[tgt_id][req_slot] <= req_data; // write payload kept for beats and resp
		end
		if (beat_valid)
			cap_id <= beat_id; // read data trails the beat by one
		if (mem_rd_valid && mask[cap_id][mem_rd_slot])
			data_q[cap_id][mem_rd_slot] <= mem_rd_data;
		if (ret_has) begin
			resp_type <= burst_type[ret_id];
			resp_tag <= tag_q[ret_id][ret_slot];
			resp_data <= data_q[ret_id][ret_slot];
		end
	end

endmodule

//--- rtl/dram_model.sv
`timescale 1ns/1ns

module dram_model (
	input logic clk,

	input mc_pkg::mem_cmd_t mem_cmd,
	input logic [mc_pkg::row_width-1:0] mem_row,
	input logic [mc_pkg::col_width-1:0] mem_col,

	input logic beat_valid,
	input logic [mc_pkg::slot_width-1:0] beat_slot,
	input logic mem_wr_en,
	input logic [mc_pkg::data_width-1:0] mem_wr_data,

	output logic mem_rd_valid,
	output logic [mc_pkg::slot_width-1:0] mem_rd_slot,
	output logic [mc_pkg::data_width-1:0] mem_rd_data
);

	logic [mc_pkg::data_width-1:0] mem [2**mc_pkg::addr_width]; // 4096 words

	logic row_open;
	logic [mc_pkg::row_width-1:0] open_row;
	logic [mc_pkg::col_width-1:0] open_col;
	logic rd_dir; // 1 after cmd_read
	logic [mc_pkg::addr_width-1:0] beat_addr;

	assign beat_addr = {open_row, open_col, beat_slot};

	// command decode
	always_ff @(posedge clk) begin
		case (mem_cmd)
			mc_pkg::cmd_activate: begin
				open_row <= mem_row;
				row_open <= 1'b1;
			end
			mc_pkg::cmd_read: begin
				open_col <= mem_col;
				rd_dir <= 1'b1;
			end
			mc_pkg::cmd_write: begin
				open_col <= mem_col;
				rd_dir <= 1'b0;
			end
			mc_pkg::cmd_precharge: row_open <= 1'b0; // bank closed
			default: ;
		endcase
	end

	// data beats
	always_ff @(posedge clk) begin
		mem_rd_valid <= beat_valid && row_open && rd_dir; // low without a beat
		if (beat_valid && row_open && !rd_dir && mem_wr_en)
			mem[beat_addr] <= mem_wr_data; // unmasked slots skipped
		if (beat_valid && row_open && rd_dir) begin
			mem_rd_data <= mem[beat_addr];
			mem_rd_slot <= beat_slot;
		end
	end

endmodule

//--- rtl/mc_pkg.sv
package mc_pkg;

	// word address split
	localparam int addr_width = 12;
	localparam int row_width = 4; // addr 11..8
	localparam int col_width = 4; // burst column, addr 7..4
	localparam int slot_width = 4; // word within burst, addr 3..0

	localparam int data_width = 32;
	localparam int tag_width = 4; // client request index
	localparam int burst_length = 16; // slots per burst

	// life of one burst buffer
	typedef enum logic [2:0] {
		empty, // free for a new burst
		filling, // still taking requests
		full, // closed, waiting for the controller
		in_service, // command sequence running
		returning // handing responses back
	} burst_state_t;

	typedef enum logic {
		read_req,
		write_req
	} req_type_t;

	// dram command bus
	typedef enum logic [2:0] {
		cmd_none,
		cmd_activate,
		cmd_read,
		cmd_write,
		cmd_precharge
	} mem_cmd_t;

endpackage

//--- rtl/mem_ctrl_top.sv
`timescale 1ns/1ns

module mem_ctrl_top #(
	parameter int no_of_bursts = 4,
	parameter int rd_to_data = 11,
	parameter int wr_to_data = 8,
	parameter int t_rcd = 4,
	parameter int t_rp = 3
) (
	input logic clk,
	input logic rst_n,

	input logic req_valid,
	input mc_pkg::req_type_t req_type,
	input logic [mc_pkg::addr_width-1:0] req_addr,
	input logic [mc_pkg::data_width-1:0] req_data,
	input logic [mc_pkg::tag_width-1:0] req_tag,
	output logic [$clog2(no_of_bursts+1)-1:0] free_bursts,

	output logic resp_valid,
	output mc_pkg::req_type_t resp_type,
	output logic [mc_pkg::tag_width-1:0] resp_tag,
	output logic [mc_pkg::data_width-1:0] resp_data
);

	localparam int id_width = $clog2(no_of_bursts);

	// handler to controller
	mc_pkg::burst_state_t [no_of_bursts-1:0] burst_state;
	mc_pkg::req_type_t [no_of_bursts-1:0] burst_type;
	logic [no_of_bursts-1:0][mc_pkg::row_width+mc_pkg::col_width-1:0] burst_row;
	logic svc_start, svc_done;
	logic [id_width-1:0] svc_id, beat_id;
	logic beat_valid;
	logic [mc_pkg::slot_width-1:0] beat_slot;

	// dram side
	mc_pkg::mem_cmd_t mem_cmd;
	logic [mc_pkg::row_width-1:0] mem_row;
	logic [mc_pkg::col_width-1:0] mem_col;
	logic mem_wr_en;
	logic [mc_pkg::data_width-1:0] mem_wr_data, mem_rd_data;
	logic mem_rd_valid;
	logic [mc_pkg::slot_width-1:0] mem_rd_slot;

	burst_handler #(
		.no_of_bursts(no_of_bursts)
	) handler_i (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_type(req_type), .req_addr(req_addr),
		.req_data(req_data), .req_tag(req_tag), .free_bursts(free_bursts),
		.svc_start(svc_start), .svc_done(svc_done), .svc_id(svc_id),
		.beat_valid(beat_valid), .beat_slot(beat_slot), .beat_id(beat_id),
		.burst_state(burst_state), .burst_type(burst_type), .burst_row(burst_row),
		.mem_rd_valid(mem_rd_valid), .mem_rd_slot(mem_rd_slot), .mem_rd_data(mem_rd_data),
		.mem_wr_data(mem_wr_data), .mem_wr_en(mem_wr_en),
		.resp_valid(resp_valid), .resp_type(resp_type), .resp_tag(resp_tag),
		.resp_data(resp_data)
	);

	timing_controller #(
		.no_of_bursts(no_of_bursts),
		.rd_to_data(rd_to_data),
		.wr_to_data(wr_to_data),
		.t_rcd(t_rcd),
		.t_rp(t_rp)
	) timing_i (
		.clk(clk), .rst_n(rst_n),
		.burst_state(burst_state), .burst_type(burst_type), .burst_row(burst_row),
		.svc_start(svc_start), .svc_done(svc_done), .svc_id(svc_id),
		.beat_valid(beat_valid), .beat_slot(beat_slot), .beat_id(beat_id),
		.mem_cmd(mem_cmd), .mem_row(mem_row), .mem_col(mem_col)
	);

	dram_model dram_i (
		.clk(clk),
		.mem_cmd(mem_cmd), .mem_row(mem_row), .mem_col(mem_col),
		.beat_valid(beat_valid), .beat_slot(beat_slot),
		.mem_wr_en(mem_wr_en), .mem_wr_data(mem_wr_data),
		.mem_rd_valid(mem_rd_valid), .mem_rd_slot(mem_rd_slot), .mem_rd_data(mem_rd_data)
	);

endmodule

//--- rtl/timing_controller.sv
`timescale 1ns/1ns

module timing_controller #(
	parameter int no_of_bursts = 4,
	parameter int rd_to_data = 11,
	parameter int wr_to_data = 8,
	parameter int t_rcd = 4,
	parameter int t_rp = 3
) (
	input logic clk,
	input logic rst_n,

	input mc_pkg::burst_state_t [no_of_bursts-1:0] burst_state,
	input mc_pkg::req_type_t [no_of_bursts-1:0] burst_type,
	input logic [no_of_bursts-1:0][mc_pkg::row_width+mc_pkg::col_width-1:0] burst_row,

	output logic svc_start,
	output logic svc_done,
	output logic [$clog2(no_of_bursts)-1:0] svc_id,

	output logic beat_valid,
	output logic [mc_pkg::slot_width-1:0] beat_slot,
	output logic [$clog2(no_of_bursts)-1:0] beat_id,

	output mc_pkg::mem_cmd_t mem_cmd,
	output logic [mc_pkg::row_width-1:0] mem_row,
	output logic [mc_pkg::col_width-1:0] mem_col
);

	localparam int id_width = $clog2(no_of_bursts);

	// counter sized for the longest phase
	localparam int dly_data = rd_to_data > wr_to_data ? rd_to_data : wr_to_data;
	localparam int dly_cmd = t_rcd > t_rp ? t_rcd : t_rp;
	localparam int max_dly = dly_data > dly_cmd ? dly_data : dly_cmd;
	localparam int cw = $clog2(max_dly+1);

	localparam logic [cw-1:0] rcd_ld = cw'(t_rcd-1);
	localparam logic [cw-1:0] rd_ld = cw'(rd_to_data-1);
	localparam logic [cw-1:0] wr_ld = cw'(wr_to_data-1);
	localparam logic [cw-1:0] rp_ld = cw'(t_rp-1);
	localparam logic [mc_pkg::slot_width-1:0] last_slot = mc_pkg::slot_width'(mc_pkg::burst_length-1);

	typedef enum logic [2:0] {
		tc_idle,
		tc_act_wait, // activate to column
		tc_col_wait, // column to first beat
		tc_beats,
		tc_pre_wait // precharge recovery
	} tc_state_t;

	tc_state_t state;
	logic [cw-1:0] cnt; // shared down-counter

	logic pick_any;
	logic [id_width-1:0] pick_id;

	// latched at svc_start
	logic [id_width-1:0] cur_id;
	mc_pkg::req_type_t cur_type;
	logic [mc_pkg::row_width+mc_pkg::col_width-1:0] cur_addr;

	// lowest full buffer
	always_comb begin
		pick_id = '0;
		pick_any = 1'b0;
		for (int i = no_of_bursts-1; i >= 0; i--) begin
			if (burst_state[i] == mc_pkg::full) begin
				pick_id = id_width'(i);
				pick_any = 1'b1;
			end
		end
	end

	assign svc_id = cur_id;
	assign beat_id = cur_id;
	assign mem_row = cur_addr[mc_pkg::row_width+mc_pkg::col_width-1:mc_pkg::col_width];
	assign mem_col = cur_addr[mc_pkg::col_width-1:0];

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state <= tc_idle;
			cnt <= '0;
			svc_start <= 1'b0;
			svc_done <= 1'b0;
			beat_valid <= 1'b0;
			beat_slot <= '0;
			mem_cmd <= mc_pkg::cmd_none;
		end else begin
			svc_start <= 1'b0; // strobes last one cycle
			svc_done <= 1'b0;
			mem_cmd <= mc_pkg::cmd_none;
			case (state)
				tc_idle: begin
					if (pick_any) begin
						svc_start <= 1'b1;
						mem_cmd <= mc_pkg::cmd_activate;
						cnt <= rcd_ld;
						state <= tc_act_wait;
					end
				end
				tc_act_wait: begin
					if (cnt == '0) begin
						if (cur_type == mc_pkg::read_req) begin
							mem_cmd <= mc_pkg::cmd_read;
							cnt <= rd_ld;
						end else begin
							mem_cmd <= mc_pkg::cmd_write;
							cnt <= wr_ld;
						end
						state <= tc_col_wait;
					end else
						cnt <= cnt - 1'b1;
				end
				tc_col_wait: begin
					if (cnt == '0) begin
						beat_valid <= 1'b1; // slot 0 next cycle
						beat_slot <= '0;
						state <= tc_beats;
					end else
						cnt <= cnt - 1'b1;
				end
				tc_beats: begin
					if (beat_slot == last_slot) begin
						beat_valid <= 1'b0;
						mem_cmd <= mc_pkg::cmd_precharge; // one after last beat
						svc_done <= 1'b1;
						cnt <= rp_ld;
						state <= tc_pre_wait;
					end else
						beat_slot <= beat_slot + 1'b1;
				end
				tc_pre_wait: begin
					if (cnt == '0)
						state <= tc_idle;
					else
						cnt <= cnt - 1'b1;
				end
				default: state <= tc_idle;
			endcase
		end
	end

	// burst info held for the whole sequence
	always_ff @(posedge clk) begin
		if (state == tc_idle && pick_any) begin
			cur_id <= pick_id;
			cur_type <= burst_type[pick_id];
			cur_addr <= burst_row[pick_id];
		end
	end

endmodule

//--- run.sh
#!/bin/bash
# build with Verilator and run the memory controller testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mem_ctrl_tb -f filelist.f -o mem_ctrl_sim \
	&& ./obj_dir/mem_ctrl_sim | tee /dev/stderr \
	| grep "Simulation completed successfully" > /dev/null \
	&& echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL"; exit 1; }

//--- testbench/mem_ctrl_assertions.sv
`timescale 1ns/1ns

module mem_ctrl_assertions #(
	parameter int no_of_bursts = 4
) (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic join_hit, // request merges into the filling burst
	input logic [$clog2(no_of_bursts+1)-1:0] free_bursts,
	input logic resp_valid
);

	// free counter never above the buffer count
	free_count_bound: assert property (@(posedge clk) disable iff (rst_n)
		free_bursts <= no_of_bursts)
		else $error("free_bursts %0d above buffer count", free_bursts);

	// no responses while held in reset
	quiet_in_reset: assert property (@(posedge clk)
		rst_n && $past(rst_n) |-> !resp_valid)
		else $error("resp_valid high during reset");

	// client must not open a burst with nothing free
	no_drop: assert property (@(posedge clk) disable iff (rst_n)
		req_valid && !join_hit |-> free_bursts != '0)
		else $error("request needs a new burst buffer but none is free");

endmodule

//--- testbench/mem_ctrl_tb.sv
`timescale 1ns/1ns

module mem_ctrl_tb;

	localparam int no_of_bursts = 4;
	localparam int bl = mc_pkg::burst_length;
	localparam int max_pend = 16; // expected bursts in flight
	localparam int n_runs = 40; // random runs
	localparam int total_reqs = 2 + 2*bl + 4 + n_runs*bl;
	localparam int cycles_per_burst = 80; // service plus return, generous
	localparam int timeout_ns = (total_reqs*cycles_per_burst + 1000) * 40;

	logic clk;
	logic rst_n;
	logic req_valid;
	mc_pkg::req_type_t req_type;
	logic [mc_pkg::addr_width-1:0] req_addr;
	logic [mc_pkg::data_width-1:0] req_data;
	logic [mc_pkg::tag_width-1:0] req_tag;
	logic [$clog2(no_of_bursts+1)-1:0] free_bursts;
	logic resp_valid;
	mc_pkg::req_type_t resp_type;
	logic [mc_pkg::tag_width-1:0] resp_tag;
	logic [mc_pkg::data_width-1:0] resp_data;

	// reference memory, updated when a write burst is formed
	logic [31:0] ref_mem [4096];
	logic written [4096];
	logic pend_any [4096]; // address in some unanswered burst
	logic pend_wr [4096]; // ... in an unanswered write burst
	logic burst_seen [256];
	logic [7:0] wr_bursts [$]; // burst addresses holding written words

	// expected bursts, slots ascending
	logic exp_busy [max_pend];
	int exp_len [max_pend];
	mc_pkg::req_type_t exp_type [max_pend];
	logic [3:0] exp_tag [max_pend][bl];
	logic [31:0] exp_data [max_pend][bl];
	int pending; // bursts not yet answered

	// current run, in send order
	int run_n;
	logic [3:0] run_slot [bl];
	logic [31:0] run_data [bl];
	logic [3:0] run_tag [bl];
	logic [3:0] next_tag;
	string test_name;

	// one returned burst, collected by the monitor
	logic [3:0] got_tag [$];
	mc_pkg::req_type_t got_type [$];
	logic [31:0] got_data [$];

	mem_ctrl_top #(
		.no_of_bursts(no_of_bursts),
		.rd_to_data(11),
		.wr_to_data(8),
		.t_rcd(4),
		.t_rp(3)
	) dut_i (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_type(req_type), .req_addr(req_addr),
		.req_data(req_data), .req_tag(req_tag), .free_bursts(free_bursts),
		.resp_valid(resp_valid), .resp_type(resp_type), .resp_tag(resp_tag),
		.resp_data(resp_data)
	);

	bind burst_handler mem_ctrl_assertions #(.no_of_bursts(no_of_bursts)) asrt_i (
		.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .join_hit(join_hit),
		.free_bursts(free_bursts), .resp_valid(resp_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual)
			fail_run($sformatf("CHECK FAILED [%s] %s: expected %0h, actual %0h",
				test_name, what, expected, actual));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#5; // drive point
	endtask

	task automatic idle(input int n);
		req_valid = 1'b0;
		repeat (n)
			next_cycle();
	endtask

	task automatic send(input mc_pkg::req_type_t t, input logic [11:0] a,
			input logic [31:0] d, input logic [3:0] tg);
		req_valid = 1'b1;
		req_type = t;
		req_addr = a;
		req_data = d;
		req_tag = tg;
		next_cycle();
	endtask

	// wait until every recorded burst came back
	task automatic drain();
		req_valid = 1'b0;
		while (pending != 0)
			next_cycle();
		for (int a = 0; a < 4096; a++) begin
			pend_any[a] = 1'b0;
			pend_wr[a] = 1'b0;
		end
	endtask

	task automatic shuffle_slots(input int n);
		int j;
		logic [3:0] t;
		for (int i = n-1; i > 0; i--) begin
			j = int'($urandom % (i+1));
			t = run_slot[i];
			run_slot[i] = run_slot[j];
			run_slot[j] = t;
		end
	endtask

	// expected responses of one burst, from the reference at forming time
	task automatic record_burst(input mc_pkg::req_type_t t, input logic [7:0] burst);
		int e;
		int s;
		logic clash;
		logic [11:0] a;
		logic have [bl];
		logic [3:0] tg [bl];
		logic [31:0] dt [bl];
		e = -1;
		clash = 1'b0;
		for (int k = 0; k < run_n; k++) begin
			a = {burst, run_slot[k]};
			if (t == mc_pkg::write_req ? pend_any[a] : pend_wr[a])
				clash = 1'b1; // service order could swap them
		end
		if (clash)
			drain();
		for (int i = 0; i < max_pend; i++)
			if (!exp_busy[i] && e < 0)
				e = i;
		if (e < 0)
			fail_run("no room left in the expected burst list");
		else begin
			for (int i = 0; i < bl; i++)
				have[i] = 1'b0;
			for (int k = 0; k < run_n; k++) begin
				s = run_slot[k];
				a = {burst, run_slot[k]};
				run_tag[k] = next_tag;
				next_tag = next_tag + 4'd1;
				have[s] = 1'b1;
				tg[s] = run_tag[k];
				dt[s] = (t == mc_pkg::write_req) ? run_data[k] : ref_mem[a];
				pend_any[a] = 1'b1;
				if (t == mc_pkg::write_req) begin
					pend_wr[a] = 1'b1;
					ref_mem[a] = run_data[k];
					written[a] = 1'b1;
				end
			end
			if (t == mc_pkg::write_req && !burst_seen[burst]) begin
				burst_seen[burst] = 1'b1;
				wr_bursts.push_back(burst);
			end
			exp_len[e] = 0;
			exp_type[e] = t;
			for (int i = 0; i < bl; i++) begin
				if (have[i]) begin
					exp_tag[e][exp_len[e]] = tg[i];
					exp_data[e][exp_len[e]] = dt[i];
					exp_len[e]++;
				end
			end
			exp_busy[e] = 1'b1;
			pending++;
		end
	endtask

	// one run back to back, then an idle cycle closes the burst
	task automatic send_run(input mc_pkg::req_type_t t, input logic [7:0] burst);
		record_burst(t, burst);
		while (free_bursts == '0)
			next_cycle();
		for (int k = 0; k < run_n; k++)
			send(t, {burst, run_slot[k]}, run_data[k], run_tag[k]);
		idle(1);
	endtask

	function automatic logic same_burst(input int e);
		logic ok;
		ok = exp_len[e] == got_tag.size();
		for (int k = 0; k < exp_len[e]; k++)
			if (ok && (exp_tag[e][k] !== got_tag[k] || exp_type[e] !== got_type[k]
					|| exp_data[e][k] !== got_data[k]))
				ok = 1'b0;
		return ok;
	endfunction

	// find the recorded burst this response run belongs to
	task automatic match_burst();
		int hit;
		int near;
		hit = -1;
		near = -1;
		for (int e = 0; e < max_pend; e++) begin
			if (exp_busy[e] && hit < 0 && same_burst(e))
				hit = e;
			if (exp_busy[e] && near < 0 && exp_tag[e][0] == got_tag[0]
					&& exp_type[e] == got_type[0])
				near = e; // fallback, for a readable mismatch
		end
		if (hit < 0 && near < 0)
			fail_run($sformatf("[%s] %0d responses starting with tag %0h match no request",
				test_name, got_tag.size(), got_tag[0]));
		else begin
			if (hit < 0)
				hit = near;
			check("burst length", exp_len[hit], got_tag.size());
			for (int k = 0; k < exp_len[hit]; k++) begin
				check("resp_tag", exp_tag[hit][k], got_tag[k]);
				check("resp_type", exp_type[hit], got_type[k]);
				check("resp_data", exp_data[hit][k], got_data[k]);
			end
			exp_busy[hit] = 1'b0;
			pending--;
			got_tag.delete();
			got_type.delete();
			got_data.delete();
		end
	endtask

	// responses of a burst come on consecutive cycles, a gap ends it
	always @(negedge clk) begin
		if (resp_valid === 1'b1) begin
			got_tag.push_back(resp_tag);
			got_type.push_back(resp_type);
			got_data.push_back(resp_data);
		end else if (got_tag.size() != 0)
			match_burst();
	end

	task automatic test_reset();
		test_name = "reset";
		repeat (8) begin // held for 8 cycles
			next_cycle();
			check("resp_valid", 0, resp_valid);
			check("free_bursts", no_of_bursts, free_bursts);
		end
		rst_n = 1'b0;
		repeat (4) begin
			next_cycle();
			check("resp_valid", 0, resp_valid);
			check("free_bursts", no_of_bursts, free_bursts);
		end
	endtask

	task automatic test_single();
		test_name = "single";
		run_n = 1;
		run_slot[0] = 4'h5;
		run_data[0] = $urandom;
		send_run(mc_pkg::write_req, 8'h3a);
		idle(6);
		run_data[0] = $urandom; // ignored on reads
		send_run(mc_pkg::read_req, 8'h3a); // read data from the write
		drain();
	endtask

	task automatic test_full_burst();
		test_name = "full_burst";
		run_n = bl;
		for (int i = 0; i < bl; i++) begin
			run_slot[i] = 4'(i);
			run_data[i] = $urandom;
		end
		shuffle_slots(bl);
		send_run(mc_pkg::write_req, 8'h7c);
		shuffle_slots(bl);
		send_run(mc_pkg::read_req, 8'h7c);
		drain();
	endtask

	task automatic test_fill_all();
		logic [7:0] burst;
		test_name = "fill_all";
		drain();
		check("free_bursts idle", no_of_bursts, free_bursts);
		for (int r = 0; r < 4; r++) begin // new row each cycle
			burst = {4'(r + 4), 4'($urandom)};
			run_n = 1;
			run_slot[0] = 4'($urandom);
			run_data[0] = $urandom;
			record_burst(mc_pkg::write_req, burst);
			send(mc_pkg::write_req, {burst, run_slot[0]}, run_data[0], run_tag[0]);
		end
		check("free_bursts all taken", 0, free_bursts);
		idle(1);
		drain();
		next_cycle();
		check("free_bursts released", no_of_bursts, free_bursts);
	endtask

	task automatic test_random();
		logic rd;
		logic [7:0] burst;
		int m;
		test_name = "random";
		for (int r = 0; r < n_runs; r++) begin
			rd = $urandom % 2 == 1 && wr_bursts.size() != 0;
			if (rd) begin // only written words
				burst = wr_bursts[$urandom % wr_bursts.size()];
				m = 0;
				for (int s = 0; s < bl; s++) begin
					if (written[{burst, 4'(s)}]) begin
						run_slot[m] = 4'(s);
						m++;
					end
				end
				shuffle_slots(m);
				run_n = 1 + int'($urandom % m);
			end else begin
				burst = 8'($urandom);
				for (int s = 0; s < bl; s++)
					run_slot[s] = 4'(s);
				shuffle_slots(bl);
				run_n = 1 + int'($urandom % bl);
			end
			for (int k = 0; k < run_n; k++)
				run_data[k] = $urandom;
			send_run(rd ? mc_pkg::read_req : mc_pkg::write_req, burst);
			idle(int'($urandom % 3));
		end
		drain();
	endtask

	task automatic test_quiet();
		test_name = "quiet";
		drain();
		next_cycle();
		check("free_bursts", no_of_bursts, free_bursts);
		repeat (100) begin
			next_cycle();
			check("resp_valid", 0, resp_valid);
		end
	endtask

	// watchdog sized from the request count
	initial begin
		#(timeout_ns);
		fail_run($sformatf("[%s] watchdog expired, responses stopped coming", test_name));
	end

	initial begin
		void'($urandom(32'ha606));
		rst_n = 1'b1; // reset is active high
		req_valid = 1'b0;
		req_type = mc_pkg::read_req;
		req_addr = '0;
		req_data = '0;
		req_tag = '0;
		pending = 0;
		run_n = 0;
		next_tag = '0;
		test_name = "init";
		for (int i = 0; i < max_pend; i++)
			exp_busy[i] = 1'b0;
		for (int a = 0; a < 4096; a++) begin
			written[a] = 1'b0;
			pend_any[a] = 1'b0;
			pend_wr[a] = 1'b0;
		end
		for (int b = 0; b < 256; b++)
			burst_seen[b] = 1'b0;
		test_reset();
		test_single();
		test_full_burst();
		test_fill_all();
		test_random();
		test_quiet();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
